// ==== all.f ====
logic/mem_cfg_pkg.sv
logic/mem_ctrl_pkg.sv
logic/mem_init_fsm.sv
logic/mem_port_ctrl.sv
logic/mem_ram_core.sv
logic/mem_ram_tdp.sv
dv/mem_ram_tdp_tb.sv

// ==== Bender.yml ====
package:
  name: mem_ram_tdp

sources:
  # Packages first, then the RTL bottom up
  - files:
      - logic/mem_cfg_pkg.sv
      - logic/mem_ctrl_pkg.sv
      - logic/mem_init_fsm.sv
      - logic/mem_port_ctrl.sv
      - logic/mem_ram_core.sv
      - logic/mem_ram_tdp.sv

  # Testbench
  - target: test
    files:
      - dv/mem_ram_tdp_tb.sv

// ==== dv/mem_ram_tdp_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ram_tdp_tb;
    import mem_cfg_pkg::*;

    // ============================================================
    // Test sizing
    // ============================================================

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int N_CLEAR_RD = 16;
    localparam int N_PIPE_RD  = 32;
    localparam int NUM_TESTS  = 6;

    // Request cycles issued over all tests
    localparam int OPS_TOTAL = N_CLEAR_RD + 4 + (DEPTH / 2 + N_PIPE_RD) + 3 + 2 + 3;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_TESTS * DEPTH + OPS_TOTAL) * (RD_LATENCY + 2);

    // ============================================================
    // DUT signals and model state
    // ============================================================

    logic clk;
    logic rst;
    logic rdy;
    logic en_0;
    logic wr_0;
    logic [ADDR_WID-1:0] addr_0;
    logic [DATA_WID-1:0] wr_data_0;
    logic [DATA_WID-1:0] rd_data_0;
    logic rd_ack_0;
    logic en_1;
    logic wr_1;
    logic [ADDR_WID-1:0] addr_1;
    logic [DATA_WID-1:0] wr_data_1;
    logic [DATA_WID-1:0] rd_data_1;
    logic rd_ack_1;

    // Shadow of the array that is cleared with every reset
    logic [DATA_WID-1:0] shadow [DEPTH];

    // Expected and returned read data per port
    logic [DATA_WID-1:0] exp_0 [$];
    logic [DATA_WID-1:0] exp_1 [$];
    logic [DATA_WID-1:0] got_0 [$];
    logic [DATA_WID-1:0] got_1 [$];

    integer seed;
    int errors;
    int tests_run;
    int tests_failed;

    mem_ram_tdp mem_ram_tdp_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .en_0      (en_0),
        .wr_0      (wr_0),
        .addr_0    (addr_0),
        .wr_data_0 (wr_data_0),
        .rd_data_0 (rd_data_0),
        .rd_ack_0  (rd_ack_0),
        .en_1      (en_1),
        .wr_1      (wr_1),
        .addr_1    (addr_1),
        .wr_data_1 (wr_data_1),
        .rd_data_1 (rd_data_1),
        .rd_ack_1  (rd_ack_1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (rd_ack_0) begin
            got_0.push_back(rd_data_0);
        end
        if (rd_ack_1) begin
            got_1.push_back(rd_data_1);
        end
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [ADDR_WID-1:0] rand_addr();
        return ADDR_WID'($random(seed));
    endfunction

    function automatic logic [DATA_WID-1:0] rand_data();
        return DATA_WID'($random(seed));
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        en_0 = 1'b0;
        en_1 = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = '0;
        end
        exp_0.delete();
        exp_1.delete();
        got_0.delete();
        got_1.delete();
    endtask

    task automatic wait_ready();
        while (!rdy) @(negedge clk);
    endtask

    // One request cycle on both ports, with the shadow updated to match
    task automatic drive_cycle(
        input logic                e0,
        input logic                w0,
        input logic [ADDR_WID-1:0] a0,
        input logic [DATA_WID-1:0] d0,
        input logic                e1,
        input logic                w1,
        input logic [ADDR_WID-1:0] a1,
        input logic [DATA_WID-1:0] d1
    );
        @(negedge clk);
        en_0 = e0;
        wr_0 = w0;
        addr_0 = a0;
        wr_data_0 = d0;
        en_1 = e1;
        wr_1 = w1;
        addr_1 = a1;
        wr_data_1 = d1;
        // Reads see the array before this cycle's writes
        if (e0 && !w0) begin
            exp_0.push_back(shadow[a0]);
        end
        if (e1 && !w1) begin
            exp_1.push_back(shadow[a1]);
        end
        // Port 0 lands last, so it owns a shared address
        if (e1 && w1) begin
            shadow[a1] = d1;
        end
        if (e0 && w0) begin
            shadow[a0] = d0;
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        en_0 = 1'b0;
        en_1 = 1'b0;
    endtask

    task automatic collect_and_check(input string name);
        logic [DATA_WID-1:0] exp_val;
        logic [DATA_WID-1:0] got_val;
        while (got_0.size() < exp_0.size() || got_1.size() < exp_1.size()) @(posedge clk);
        // Room for a stray acknowledge
        repeat (RD_LATENCY + 1) @(posedge clk);
        assert (got_0.size() == exp_0.size()) else begin
            $display("%s: port 0 gave %0d read acknowledges, %0d were expected",
                     name, got_0.size(), exp_0.size());
            errors++;
        end
        assert (got_1.size() == exp_1.size()) else begin
            $display("%s: port 1 gave %0d read acknowledges, %0d were expected",
                     name, got_1.size(), exp_1.size());
            errors++;
        end
        while (exp_0.size() > 0 && got_0.size() > 0) begin
            exp_val = exp_0.pop_front();
            got_val = got_0.pop_front();
            assert (got_val === exp_val) else begin
                $display("error: %s port 0 expected %h actual %h", name, exp_val, got_val);
                errors++;
            end
        end
        while (exp_1.size() > 0 && got_1.size() > 0) begin
            exp_val = exp_1.pop_front();
            got_val = got_1.pop_front();
            assert (got_val === exp_val) else begin
                $display("error: %s port 1 expected %h actual %h", name, exp_val, got_val);
                errors++;
            end
        end
        exp_0.delete();
        exp_1.delete();
        got_0.delete();
        got_1.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic test_clear();
        int errs_before;
        errs_before = errors;
        for (int i = 0; i < N_CLEAR_RD; i++) begin
            drive_cycle(1'b1, 1'b0, rand_addr(), '0, 1'b1, 1'b0, rand_addr(), '0);
        end
        drive_idle();
        collect_and_check("clear_after_reset");
        finish_test("clear_after_reset", errs_before);
    endtask

    task automatic test_cross_port();
        int errs_before;
        logic [ADDR_WID-1:0] a;
        errs_before = errors;
        a = rand_addr();
        drive_cycle(1'b1, 1'b1, a, rand_data(), 1'b0, 1'b0, '0, '0);
        drive_cycle(1'b1, 1'b0, a, '0, 1'b1, 1'b0, a, '0);
        a = rand_addr();
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, a, rand_data());
        drive_cycle(1'b1, 1'b0, a, '0, 1'b1, 1'b0, a, '0);
        drive_idle();
        collect_and_check("cross_port");
        finish_test("cross_port", errs_before);
    endtask

    task automatic test_pipelined_reads();
        int errs_before;
        errs_before = errors;
        // Even entries from port 0, odd ones from port 1
        for (int i = 0; i < DEPTH / 2; i++) begin
            drive_cycle(1'b1, 1'b1, ADDR_WID'(2 * i), rand_data(),
                        1'b1, 1'b1, ADDR_WID'(2 * i + 1), rand_data());
        end
        for (int i = 0; i < N_PIPE_RD; i++) begin
            drive_cycle(1'b1, 1'b0, rand_addr(), '0, 1'b1, 1'b0, rand_addr(), '0);
        end
        drive_idle();
        collect_and_check("pipelined_reads");
        finish_test("pipelined_reads", errs_before);
    endtask

    task automatic test_read_during_write();
        int errs_before;
        logic [ADDR_WID-1:0] a;
        errs_before = errors;
        a = rand_addr();
        drive_cycle(1'b1, 1'b1, a, rand_data(), 1'b0, 1'b0, '0, '0);
        // Port 1 should get the value written one cycle earlier
        drive_cycle(1'b1, 1'b1, a, rand_data(), 1'b1, 1'b0, a, '0);
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, a, '0);
        drive_idle();
        collect_and_check("read_during_write");
        finish_test("read_during_write", errs_before);
    endtask

    task automatic test_double_write();
        int errs_before;
        logic [ADDR_WID-1:0] a;
        errs_before = errors;
        a = rand_addr();
        drive_cycle(1'b1, 1'b1, a, rand_data(), 1'b1, 1'b1, a, rand_data());
        drive_cycle(1'b1, 1'b0, a, '0, 1'b1, 1'b0, a, '0);
        drive_idle();
        collect_and_check("double_write");
        finish_test("double_write", errs_before);
    endtask

    task automatic test_requests_during_clear();
        int errs_before;
        logic [ADDR_WID-1:0] a;
        errs_before = errors;
        a = rand_addr();
        apply_reset();
        @(negedge clk);
        assert (!rdy) else begin
            $display("requests_during_clear: rdy was already high during the clear");
            errors++;
        end
        // A write and a read held on every cycle of the clear
        // All of them are dropped and the shadow stays untouched
        en_0 = 1'b1;
        wr_0 = 1'b1;
        addr_0 = a;
        wr_data_0 = rand_data();
        en_1 = 1'b1;
        wr_1 = 1'b0;
        addr_1 = a;
        wait_ready();
        // Strobes drop at the first falling edge that sees rdy
        en_0 = 1'b0;
        en_1 = 1'b0;
        collect_and_check("requests_during_clear");
        drive_cycle(1'b1, 1'b0, a, '0, 1'b1, 1'b0, a, '0);
        drive_idle();
        collect_and_check("requests_during_clear");
        finish_test("requests_during_clear", errs_before);
    endtask

    // ============================================================
    // Sequence and watchdog
    // ============================================================

    initial begin
        seed = 32'h7c90_5aef;
        rst = 1'b1;
        en_0 = 1'b0;
        wr_0 = 1'b0;
        addr_0 = '0;
        wr_data_0 = '0;
        en_1 = 1'b0;
        wr_1 = 1'b0;
        addr_1 = '0;
        wr_data_1 = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        apply_reset();
        wait_ready();
        test_clear();
        test_cross_port();
        test_pipelined_reads();
        test_read_during_write();
        test_double_write();
        test_requests_during_clear();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule : mem_ram_tdp_tb

`default_nettype wire

// ==== logic/mem_ram_tdp.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ram_tdp (
    input  wire logic                             clk,
    input  wire logic                             rst,
    output logic                                  rdy,

    // Port 0
    input  wire logic                             en_0,
    input  wire logic                             wr_0,
    input  wire logic [mem_cfg_pkg::ADDR_WID-1:0] addr_0,
    input  wire logic [mem_cfg_pkg::DATA_WID-1:0] wr_data_0,
    output logic [mem_cfg_pkg::DATA_WID-1:0]      rd_data_0,
    output logic                                  rd_ack_0,

    // Port 1
    input  wire logic                             en_1,
    input  wire logic                             wr_1,
    input  wire logic [mem_cfg_pkg::ADDR_WID-1:0] addr_1,
    input  wire logic [mem_cfg_pkg::DATA_WID-1:0] wr_data_1,
    output logic [mem_cfg_pkg::DATA_WID-1:0]      rd_data_1,
    output logic                                  rd_ack_1
);
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    // ============================================================
    // Internal wires
    // ============================================================

    // Clear path from the sequencer
    logic                init_we;
    logic [ADDR_WID-1:0] init_addr;

    // Registered requests into the core
    mem_op_e             op_0;
    logic [ADDR_WID-1:0] op_addr_0;
    logic [DATA_WID-1:0] op_data_0;
    mem_op_e             op_1;
    logic [ADDR_WID-1:0] op_addr_1;
    logic [DATA_WID-1:0] op_data_1;

    // ============================================================
    // Init sequencer
    // ============================================================

    mem_init_fsm mem_init_fsm_i (
        .clk       (clk),
        .rst       (rst),
        .init_we   (init_we),
        .init_addr (init_addr),
        .rdy       (rdy)
    );

    // ============================================================
    // Port controllers
    // ============================================================

    mem_port_ctrl port_ctrl_0 (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .en      (en_0),
        .wr      (wr_0),
        .addr    (addr_0),
        .wr_data (wr_data_0),
        .op      (op_0),
        .op_addr (op_addr_0),
        .op_data (op_data_0),
        .rd_ack  (rd_ack_0)
    );

    mem_port_ctrl port_ctrl_1 (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .en      (en_1),
        .wr      (wr_1),
        .addr    (addr_1),
        .wr_data (wr_data_1),
        .op      (op_1),
        .op_addr (op_addr_1),
        .op_data (op_data_1),
        .rd_ack  (rd_ack_1)
    );

    // ============================================================
    // Storage core
    // ============================================================

    // Read data goes straight out, rd_ack marks it valid
    mem_ram_core mem_ram_core_i (
        .clk       (clk),
        .init_we   (init_we),
        .init_addr (init_addr),
        .op_0      (op_0),
        .op_addr_0 (op_addr_0),
        .op_data_0 (op_data_0),
        .op_1      (op_1),
        .op_addr_1 (op_addr_1),
        .op_data_1 (op_data_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

endmodule : mem_ram_tdp

`default_nettype wire

// ==== logic/mem_ram_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ram_core (
    input  wire logic                             clk,
    input  wire logic                             init_we,
    input  wire logic [mem_cfg_pkg::ADDR_WID-1:0] init_addr,
    input  wire mem_ctrl_pkg::mem_op_e            op_0,
    input  wire logic [mem_cfg_pkg::ADDR_WID-1:0] op_addr_0,
    input  wire logic [mem_cfg_pkg::DATA_WID-1:0] op_data_0,
    input  wire mem_ctrl_pkg::mem_op_e            op_1,
    input  wire logic [mem_cfg_pkg::ADDR_WID-1:0] op_addr_1,
    input  wire logic [mem_cfg_pkg::DATA_WID-1:0] op_data_1,
    output logic [mem_cfg_pkg::DATA_WID-1:0]      rd_data_0,
    output logic [mem_cfg_pkg::DATA_WID-1:0]      rd_data_1
);
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    // ============================================================
    // Storage
    // ============================================================

    logic [DATA_WID-1:0] mem [DEPTH];

    // ============================================================
    // Access decode
    // ============================================================

    // Per-port write and read strobes
    logic wr_en_0;
    logic wr_en_1;
    logic rd_en_0;
    logic rd_en_1;

    // Both ports writing the same entry
    logic wr_collide;

    // Port 1 write after collision masking
    logic wr_en_1_ok;

    assign wr_en_0 = (op_0 == MEM_OP_WRITE);
    assign wr_en_1 = (op_1 == MEM_OP_WRITE);
    assign rd_en_0 = (op_0 == MEM_OP_READ);
    assign rd_en_1 = (op_1 == MEM_OP_READ);

    assign wr_collide = wr_en_0 && wr_en_1 && (op_addr_0 == op_addr_1);

    // Port 0 wins a double write
    assign wr_en_1_ok = wr_en_1 && !wr_collide;

    // ============================================================
    // Write path
    // ============================================================

    // Clear sequence has priority over port traffic
    always_ff @(posedge clk) begin
        if (init_we) begin
            mem[init_addr] <= '0;
        end else begin
            if (wr_en_0) begin
                mem[op_addr_0] <= op_data_0;
            end
            if (wr_en_1_ok) begin
                mem[op_addr_1] <= op_data_1;
            end
        end
    end

    // ============================================================
    // Read path
    // ============================================================

    // Nonblocking capture sees the pre-write contents
    // so a read against the other port's write returns old data
    always_ff @(posedge clk) begin
        if (rd_en_0) begin
            rd_data_0 <= mem[op_addr_0];
        end
    end

    // Same read-first capture for port 1
    always_ff @(posedge clk) begin
        if (rd_en_1) begin
            rd_data_1 <= mem[op_addr_1];
        end
    end

endmodule : mem_ram_core

`default_nettype wire

// ==== logic/mem_port_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_port_ctrl (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             rdy,
    input  wire logic                             en,
    input  wire logic                             wr,
    input  wire logic [mem_cfg_pkg::ADDR_WID-1:0] addr,
    input  wire logic [mem_cfg_pkg::DATA_WID-1:0] wr_data,
    output mem_ctrl_pkg::mem_op_e                 op,
    output logic [mem_cfg_pkg::ADDR_WID-1:0]      op_addr,
    output logic [mem_cfg_pkg::DATA_WID-1:0]      op_data,
    output logic                                  rd_ack
);
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    // ============================================================
    // Signals
    // ============================================================

    // Request accepted this cycle
    logic req_vld;

    // Decoded operation for the request register
    mem_op_e req_op;

    // Read flags trailing the op register
    // Core adds one edge, the rest sits here
    logic [RD_LATENCY-2:0] rd_pipe;

    // ============================================================
    // Request decode
    // ============================================================

    // Drop anything while the array is still being cleared
    assign req_vld = en && rdy;

    always_comb begin
        if (!req_vld) begin
            req_op = MEM_OP_IDLE;
        end else if (wr) begin
            req_op = MEM_OP_WRITE;
        end else begin
            req_op = MEM_OP_READ;
        end
    end

    // ============================================================
    // Request register
    // ============================================================

    // Operation code, idle under reset
    always_ff @(posedge clk) begin
        if (rst) begin
            op <= MEM_OP_IDLE;
        end else begin
            op <= req_op;
        end
    end

    // Payload follows accepted requests only
    always_ff @(posedge clk) begin
        if (req_vld) begin
            op_addr <= addr;
            if (wr) begin
                op_data <= wr_data;
            end
        end
    end

    // ============================================================
    // Read acknowledge pipeline
    // ============================================================

    // One flag per read in flight, so reads can issue every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe[0] <= (op == MEM_OP_READ);
            for (int i = 1; i < RD_LATENCY - 1; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    // Lines up with the core's read data register
    assign rd_ack = rd_pipe[RD_LATENCY-2];

endmodule : mem_port_ctrl

`default_nettype wire

// ==== logic/mem_init_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_init_fsm (
    input  wire logic                             clk,
    input  wire logic                             rst,
    output logic                                  init_we,
    output logic [mem_cfg_pkg::ADDR_WID-1:0]      init_addr,
    output logic                                  rdy
);
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    // ============================================================
    // Signals
    // ============================================================

    // Sequencer state
    mem_init_state_e state;
    mem_init_state_e nxt_state;

    // Address counter at the last entry
    logic last_entry;

    // ============================================================
    // Next-state logic
    // ============================================================

    assign last_entry = (init_addr == ADDR_WID'(DEPTH - 1));

    always_comb begin
        nxt_state = state;
        case (state)
            MEM_INIT_CLEAR: begin
                // Leave clear once the final entry is written
                if (last_entry) begin
                    nxt_state = MEM_INIT_DONE;
                end
            end
            MEM_INIT_DONE: begin
                // Stay here until the next reset
                nxt_state = MEM_INIT_DONE;
            end
            default: begin
                nxt_state = MEM_INIT_CLEAR;
            end
        endcase
    end

    // ============================================================
    // State and counter registers
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MEM_INIT_CLEAR;
        end else begin
            state <= nxt_state;
        end
    end

    // One entry per cycle while clearing
    always_ff @(posedge clk) begin
        if (rst) begin
            init_addr <= '0;
        end else if (state == MEM_INIT_CLEAR) begin
            init_addr <= init_addr + 1'b1;
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    // Write strobe for the core's clear path
    assign init_we = (state == MEM_INIT_CLEAR);

    // Ready level for both ports
    assign rdy = (state == MEM_INIT_DONE);

endmodule : mem_init_fsm

`default_nettype wire

// ==== logic/mem_ctrl_pkg.sv ====
`default_nettype none

package mem_ctrl_pkg;

    // ============================================================
    // Init sequencer
    // ============================================================

    // Clear walks the array, done holds ready
    typedef enum logic {
        MEM_INIT_CLEAR = 1'b0,
        MEM_INIT_DONE  = 1'b1
    } mem_init_state_e;

    // ============================================================
    // Port operations
    // ============================================================

    // Decoded request as seen by the core
    typedef enum logic [1:0] {
        MEM_OP_IDLE  = 2'b00,
        MEM_OP_READ  = 2'b01,
        MEM_OP_WRITE = 2'b10
    } mem_op_e;

endpackage : mem_ctrl_pkg

`default_nettype wire

// ==== logic/mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

    // ============================================================
    // RAM geometry
    // ============================================================

    // Address bits per port
    localparam int ADDR_WID = 8;

    // Data bits per entry
    localparam int DATA_WID = 32;

    // Entries in the storage array
    localparam int DEPTH = 2 ** ADDR_WID;

    // ============================================================
    // Read timing
    // ============================================================

    // Edges from request sample to valid rd_ack / rd_data
    // One edge in the port request register, one in the core
    localparam int RD_LATENCY = 2;

endpackage : mem_cfg_pkg

`default_nettype wire
